//--- Bender.yml
package:
  name: boot_soc

sources:
  - verilog/boot_pkg.sv
  - verilog/uart_rx_prog.sv
  - verilog/boot_loader.sv
  - verilog/instr_mem.sv
  - verilog/boot_soc_top.sv
  - target: simulation
    files:
      - sim/boot_soc_asserts.sv
      - sim/boot_soc_tb.sv

//--- sim/boot_soc_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module boot_soc_asserts import boot_pkg::*; (
  input logic    clk_i,
  input logic    arst_n_i,
  input tl_h2d_t tl_i,
  input tl_d2h_t tl_o,
  input logic    core_rst_n_o
);

  int fail_cnt = 0;

  // master parked while the core sits in reset
  ready_in_reset: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !core_rst_n_o |-> !tl_o.a_ready)
    else begin
      $error("a_ready high while core_rst_n_o is low");
      fail_cnt++;
    end

  // response is frozen under back-pressure
  rsp_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    tl_o.d_valid && !tl_i.d_ready |=> tl_o.d_valid && $stable(tl_o.d_opcode) &&
    $stable(tl_o.d_data) && $stable(tl_o.d_error))
    else begin
      $error("response changed while d_ready was low");
      fail_cnt++;
    end

  rsp_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    tl_i.a_valid && tl_o.a_ready |=> tl_o.d_valid)
    else begin
      $error("no response one cycle after an accepted request");
      fail_cnt++;
    end

  // single request in flight
  one_pending: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    tl_o.d_valid |-> !tl_o.a_ready)
    else begin
      $error("a_ready high while a response is pending");
      fail_cnt++;
    end

  core_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !core_rst_n_o)
    else begin
      $error("core_rst_n_o high during external reset");
      fail_cnt++;
    end

endmodule

bind boot_soc_top boot_soc_asserts u_asserts (.*);

`default_nettype wire

//--- sim/boot_soc_tb.sv
`timescale 1ns/100ps
`default_nettype none

module boot_soc_tb import boot_pkg::*; ();

  localparam int MemWords  = 256;
  localparam int ClkPeriod = 40;
  localparam int Cpb       = 16;
  // four words of four bytes plus one broken frame
  localparam int NumBytes  = 17;
  localparam int BusCycles = 400;
  localparam int TimeoutNs = 2 * (NumBytes * 10 * Cpb * ClkPeriod + BusCycles * ClkPeriod);

  logic        clk_i;
  logic        arst_n_i;
  logic        prog_i;
  logic [15:0] clks_per_bit_i;
  logic        uart_rx_i;
  tl_h2d_t     tl_i;
  tl_d2h_t     tl_o;
  logic        core_rst_n_o;
  logic [31:0] model [MemWords];
  logic [31:0] prog_words [3];
  integer      seed = 33;
  int          errors = 0;

  initial clk_i = 1'b0;
  always #(ClkPeriod / 2) clk_i = ~clk_i;

  boot_soc_top #(
    .MemWords (MemWords)
  ) DUT (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .prog_i         (prog_i),
    .clks_per_bit_i (clks_per_bit_i),
    .uart_rx_i      (uart_rx_i),
    .tl_i           (tl_i),
    .tl_o           (tl_o),
    .core_rst_n_o   (core_rst_n_o)
  );

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  // out of range or unaligned
  function automatic logic addr_bad(input logic [11:0] addr);
    return (addr[11:2] >= MemWords) || (addr[1:0] != 2'b00);
  endfunction

  // 8N1 frame, idle gap of two bit periods afterwards
  task automatic uart_send_byte(input logic [7:0] data, input logic bad_stop);
    @(posedge clk_i);
    uart_rx_i <= 1'b0;
    repeat (Cpb) @(posedge clk_i);
    for (int i = 0; i < 8; i++) begin
      uart_rx_i <= data[i];
      repeat (Cpb) @(posedge clk_i);
    end
    uart_rx_i <= ~bad_stop;
    repeat (Cpb) @(posedge clk_i);
    uart_rx_i <= 1'b1;
    repeat (2 * Cpb) @(posedge clk_i);
  endtask

  // little-endian, optional broken frame after the second byte
  task automatic uart_send_word(input logic [31:0] word, input logic inject_bad);
    for (int b = 0; b < 4; b++) begin
      uart_send_byte(word[8*b +: 8], 1'b0);
      if (inject_bad && b == 1) begin
        uart_send_byte(8'h5A, 1'b1);
      end
    end
  endtask

  // request stays up while the response is pending
  task automatic bus_access(input tl_a_op_e op, input logic [11:0] addr,
                            input logic [31:0] data, input logic [3:0] mask,
                            output tl_d2h_t rsp);
    @(posedge clk_i);
    tl_i.a_valid   <= 1'b1;
    tl_i.a_opcode  <= op;
    tl_i.a_address <= addr;
    tl_i.a_data    <= data;
    tl_i.a_mask    <= mask;
    tl_i.d_ready   <= 1'b0;
    @(negedge clk_i);
    while (!tl_o.a_ready) begin
      @(negedge clk_i);
    end
    do begin
      @(posedge clk_i);
      // ready low about one cycle in four
      tl_i.d_ready <= (($random(seed) & 3) != 0);
      @(negedge clk_i);
    end while (!(tl_o.d_valid && tl_i.d_ready));
    rsp = tl_o;
    @(posedge clk_i);
    tl_i <= '0;
  endtask

  task automatic bus_get(input logic [11:0] addr);
    tl_d2h_t     rsp;
    logic [31:0] exp;
    exp = addr_bad(addr) ? 32'h0 : model[addr[11:2]];
    bus_access(Get, addr, 32'h0, 4'h0, rsp);
    check_eq("d_opcode", AccessAckData, rsp.d_opcode);
    check_eq("d_error", addr_bad(addr), rsp.d_error);
    check_eq("d_data", exp, rsp.d_data);
  endtask

  task automatic bus_put(input logic [11:0] addr, input logic [31:0] data,
                         input logic [3:0] mask);
    tl_d2h_t rsp;
    bus_access(PutFullData, addr, data, mask, rsp);
    check_eq("d_opcode", AccessAck, rsp.d_opcode);
    check_eq("d_error", addr_bad(addr), rsp.d_error);
    if (!addr_bad(addr)) begin
      for (int b = 0; b < 4; b++) begin
        if (mask[b]) begin
          model[addr[11:2]][8*b +: 8] = data[8*b +: 8];
        end
      end
    end
  endtask

  initial begin
    int n;
    arst_n_i       = 1'b0;
    prog_i         = 1'b0;
    clks_per_bit_i = 16'(Cpb);
    uart_rx_i      = 1'b1;
    tl_i           = '0;
    prog_words[0]  = 32'h1234_5678;
    prog_words[1]  = 32'hDEAD_BEEF;
    prog_words[2]  = 32'h0BAD_F00D;
    repeat (3) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    check_eq("core_rst_n_o", 1'b1, core_rst_n_o);

    // bus is live straight after reset
    bus_put(12'h000, 32'h0102_0304, 4'hF);
    bus_get(12'h000);

    // boot image with a framing error inside word 1
    @(posedge clk_i);
    prog_i <= 1'b1;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    check_eq("core_rst_n_o", 1'b0, core_rst_n_o);
    for (int i = 0; i < 3; i++) begin
      uart_send_word(prog_words[i], i == 1);
      model[i] = prog_words[i];
    end
    for (int b = 0; b < 4; b++) begin
      @(negedge clk_i);
      check_eq("core_rst_n_o", 1'b0, core_rst_n_o);
      uart_send_byte(BOOT_END_WORD[8*b +: 8], 1'b0);
    end
    n = 0;
    while (!core_rst_n_o && n < 4 * Cpb) begin
      @(negedge clk_i);
      n++;
    end
    check_eq("core_rst_n_o", 1'b1, core_rst_n_o);
    @(posedge clk_i);
    prog_i <= 1'b0;
    for (int i = 0; i < 3; i++) begin
      bus_get(12'(4 * i));
    end

    // partial mask merge
    bus_put(12'h004, 32'hA1B2_C3D4, 4'b0110);
    bus_get(12'h004);

    // range and alignment errors
    bus_get(12'(MemWords * 4));
    bus_put(12'(MemWords * 4), 32'hFFFF_FFFF, 4'hF);
    bus_put(12'h009, 32'h5555_5555, 4'hF);
    bus_get(12'h006);
    bus_get(12'h008);
    bus_get(12'h000);

    repeat (4) @(posedge clk_i);
    $display("checks failed: %0d, assertions failed: %0d", errors, DUT.u_asserts.fail_cnt);
    if (errors == 0 && DUT.u_asserts.fail_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin
    #(TimeoutNs);
    $display("watchdog expired before the tests finished");
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
verilog/boot_pkg.sv
verilog/uart_rx_prog.sv
verilog/boot_loader.sv
verilog/instr_mem.sv
verilog/boot_soc_top.sv
sim/boot_soc_asserts.sv
sim/boot_soc_tb.sv

//--- verilog/boot_loader.sv
`timescale 1ns/100ps
`default_nettype none

module boot_loader import boot_pkg::*; #(
  parameter int MemWords = 256
) (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        prog_i,
  input  logic                        rx_dv_i,
  input  logic [7:0]                  rx_byte_i,
  output logic                        we_o,
  output logic [$clog2(MemWords)-1:0] addr_o,
  output logic [31:0]                 wdata_o,
  output logic                        prog_rst_n_o
);

  localparam int AddrW = $clog2(MemWords);

  boot_state_e      state_q;
  logic             prog_q;
  logic             prog_rise;
  logic [1:0]       byte_cnt_q;
  logic [31:0]      word_q;
  logic [31:0]      word_next;
  logic [AddrW-1:0] addr_q;
  logic             prog_rst_n_q;

  assign prog_rise = prog_i & ~prog_q;
  // little-endian, so the newest byte enters at the top
  assign word_next = {rx_byte_i, word_q[31:8]};

  always_ff @(posedge clk_i) begin
    if (rx_dv_i && (state_q == BOOT_COLLECT)) begin
      word_q <= word_next;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q      <= BOOT_IDLE;
      prog_q       <= 1'b0;
      byte_cnt_q   <= '0;
      addr_q       <= '0;
      prog_rst_n_q <= 1'b1;
    end else begin
      prog_q <= prog_i;
      case (state_q)
        BOOT_IDLE, BOOT_DONE: begin
          if (prog_rise) begin
            addr_q       <= '0;
            byte_cnt_q   <= '0;
            prog_rst_n_q <= 1'b0;
            state_q      <= BOOT_COLLECT;
          end
        end
        BOOT_COLLECT: begin
          if (rx_dv_i) begin
            byte_cnt_q <= byte_cnt_q + 2'd1;
            if (byte_cnt_q == 2'd3) begin
              // end marker is never stored
              if (word_next == BOOT_END_WORD) begin
                prog_rst_n_q <= 1'b1;
                state_q      <= BOOT_DONE;
              end else begin
                state_q <= BOOT_WRITE;
              end
            end
          end
        end
        BOOT_WRITE: begin
          // wraps past the last word
          addr_q  <= addr_q + 1'b1;
          state_q <= BOOT_COLLECT;
        end
        default: state_q <= BOOT_IDLE;
      endcase
    end
  end

  assign we_o         = (state_q == BOOT_WRITE);
  assign addr_o       = addr_q;
  assign wdata_o      = word_q;
  assign prog_rst_n_o = prog_rst_n_q;

endmodule

`default_nettype wire

//--- verilog/boot_pkg.sv
`default_nettype none

package boot_pkg;

  // TL-UL channel A opcodes, only the two the memory serves
  typedef enum logic [2:0] {
    PutFullData = 3'h0,
    Get         = 3'h4
  } tl_a_op_e;

  // channel D opcodes
  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

  typedef struct packed {
    logic        a_valid;
    tl_a_op_e    a_opcode;
    logic [11:0] a_address;
    logic [31:0] a_data;
    logic [3:0]  a_mask;
    logic        d_ready;
  } tl_h2d_t;

  typedef struct packed {
    logic        d_valid;
    tl_d_op_e    d_opcode;
    logic [31:0] d_data;
    logic        d_error;
    logic        a_ready;
  } tl_d2h_t;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP,
    RX_CLEANUP
  } rx_state_e;

  typedef enum logic [1:0] {
    BOOT_IDLE,
    BOOT_COLLECT,
    BOOT_WRITE,
    BOOT_DONE
  } boot_state_e;

  // host sends this word to close the program image
  localparam logic [31:0] BOOT_END_WORD = 32'h0000_0FFF;

endpackage

`default_nettype wire

//--- verilog/boot_soc_top.sv
`timescale 1ns/100ps
`default_nettype none

module boot_soc_top import boot_pkg::*; #(
  parameter int MemWords = 256
) (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        prog_i,
  input  logic [15:0] clks_per_bit_i,
  input  logic        uart_rx_i,
  input  tl_h2d_t     tl_i,
  output tl_d2h_t     tl_o,
  output logic        core_rst_n_o
);

  localparam int AddrW = $clog2(MemWords);

  logic             rx_dv;
  logic [7:0]       rx_byte;
  logic             boot_we;
  logic [AddrW-1:0] boot_addr;
  logic [31:0]      boot_wdata;
  logic             prog_rst_n;

  // core stays in reset through programming
  assign core_rst_n_o = arst_n_i & prog_rst_n;

  uart_rx_prog u_uart_rx_prog (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .rx_i           (uart_rx_i),
    .clks_per_bit_i (clks_per_bit_i),
    .rx_dv_o        (rx_dv),
    .rx_byte_o      (rx_byte)
  );

  boot_loader #(
    .MemWords (MemWords)
  ) u_boot_loader (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .prog_i       (prog_i),
    .rx_dv_i      (rx_dv),
    .rx_byte_i    (rx_byte),
    .we_o         (boot_we),
    .addr_o       (boot_addr),
    .wdata_o      (boot_wdata),
    .prog_rst_n_o (prog_rst_n)
  );

  instr_mem #(
    .MemWords (MemWords)
  ) u_instr_mem (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .core_rst_n_i (core_rst_n_o),
    .tl_i         (tl_i),
    .tl_o         (tl_o),
    .boot_we_i    (boot_we),
    .boot_addr_i  (boot_addr),
    .boot_wdata_i (boot_wdata)
  );

endmodule

`default_nettype wire

//--- verilog/instr_mem.sv
`timescale 1ns/100ps
`default_nettype none

module instr_mem import boot_pkg::*; #(
  parameter int MemWords = 256
) (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        core_rst_n_i,
  input  tl_h2d_t                     tl_i,
  output tl_d2h_t                     tl_o,
  input  logic                        boot_we_i,
  input  logic [$clog2(MemWords)-1:0] boot_addr_i,
  input  logic [31:0]                 boot_wdata_i
);

  localparam int AddrW = $clog2(MemWords);

  logic [31:0]      mem_q [MemWords];
  logic [AddrW-1:0] word_idx;
  logic             a_ready;
  logic             req_fire;
  logic             req_err;
  logic             req_write;
  logic             d_valid_q;
  tl_d_op_e         d_opcode_q;
  logic [31:0]      d_data_q;
  logic             d_error_q;

  assign word_idx = tl_i.a_address[AddrW+1:2];

  // out of range or not on a word boundary
  assign req_err = (int'(tl_i.a_address[11:2]) >= MemWords) ||
                   (tl_i.a_address[1:0] != 2'b00);

  // one request in flight, none while the core is held in reset
  assign a_ready   = core_rst_n_i & ~d_valid_q;
  assign req_fire  = tl_i.a_valid & a_ready;
  assign req_write = req_fire & (tl_i.a_opcode == PutFullData) & ~req_err;

  // boot port only writes with the core in reset, so the two never collide
  always_ff @(posedge clk_i) begin
    if (boot_we_i) begin
      mem_q[boot_addr_i] <= boot_wdata_i;
    end else if (req_write) begin
      for (int b = 0; b < 4; b++) begin
        if (tl_i.a_mask[b]) begin
          mem_q[word_idx][8*b +: 8] <= tl_i.a_data[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      d_valid_q <= 1'b0;
    end else if (req_fire) begin
      d_valid_q <= 1'b1;
    end else if (tl_i.d_ready) begin
      d_valid_q <= 1'b0;
    end
  end

  // payload only loads on acceptance, so it holds under back-pressure
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      d_error_q <= req_err;
      if (tl_i.a_opcode == Get) begin
        d_opcode_q <= AccessAckData;
        d_data_q   <= req_err ? '0 : mem_q[word_idx];
      end else begin
        d_opcode_q <= AccessAck;
        d_data_q   <= '0;
      end
    end
  end

  assign tl_o = '{
    d_valid:  d_valid_q,
    d_opcode: d_opcode_q,
    d_data:   d_data_q,
    d_error:  d_error_q,
    a_ready:  a_ready
  };

endmodule

`default_nettype wire

//--- verilog/uart_rx_prog.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx_prog import boot_pkg::*; (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        rx_i,
  input  logic [15:0] clks_per_bit_i,
  output logic        rx_dv_o,
  output logic [7:0]  rx_byte_o
);

  rx_state_e   state_q;
  logic        rx_meta_q;
  logic        rx_sync_q;
  logic [15:0] clk_cnt_q;
  logic [2:0]  bit_idx_q;
  logic [7:0]  byte_q;
  logic        dv_q;
  logic [15:0] half_cnt;
  logic [15:0] last_cnt;
  logic        sample_bit;

  // middle of the start bit, then full periods from there
  assign half_cnt   = (clks_per_bit_i - 16'd1) >> 1;
  assign last_cnt   = clks_per_bit_i - 16'd1;
  assign sample_bit = (state_q == RX_DATA) && (clk_cnt_q == last_cnt);

  // line idles high
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= RX_IDLE;
      clk_cnt_q <= '0;
      bit_idx_q <= '0;
      dv_q      <= 1'b0;
    end else begin
      dv_q <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          clk_cnt_q <= '0;
          bit_idx_q <= '0;
          if (!rx_sync_q) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          if (clk_cnt_q == half_cnt) begin
            clk_cnt_q <= '0;
            // a glitch that is gone by mid-bit is not a start bit
            state_q   <= rx_sync_q ? RX_IDLE : RX_DATA;
          end else begin
            clk_cnt_q <= clk_cnt_q + 16'd1;
          end
        end
        RX_DATA: begin
          if (sample_bit) begin
            clk_cnt_q <= '0;
            bit_idx_q <= bit_idx_q + 3'd1;
            if (bit_idx_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end else begin
            clk_cnt_q <= clk_cnt_q + 16'd1;
          end
        end
        RX_STOP: begin
          if (clk_cnt_q == last_cnt) begin
            clk_cnt_q <= '0;
            // framing error drops the byte
            dv_q      <= rx_sync_q;
            state_q   <= RX_CLEANUP;
          end else begin
            clk_cnt_q <= clk_cnt_q + 16'd1;
          end
        end
        RX_CLEANUP: state_q <= RX_IDLE;
        default:    state_q <= RX_IDLE;
      endcase
    end
  end

  // lsb first
  always_ff @(posedge clk_i) begin
    if (sample_bit) begin
      byte_q[bit_idx_q] <= rx_sync_q;
    end
  end

  assign rx_dv_o   = dv_q;
  assign rx_byte_o = byte_q;

endmodule

`default_nettype wire
